//--- hdl/cmd_queue.sv
// Command queue that buffers stream beats in a synchronous FIFO with valid/ready on both sides
`timescale 1ns/1ps
`default_nettype none

module cmd_queue #(
  parameter int DEPTH = 16
) (
  input  wire logic                   i_clk_core,
  input  wire logic                   i_rst_core,
  input  wire ctrl_pkg::stream_beat_t i_beat,
  input  wire logic                   i_val,
  output logic                        o_rdy,
  output ctrl_pkg::stream_beat_t      o_beat,
  output logic                        o_val,
  input  wire logic                   i_rdy
);
  import ctrl_pkg::*;

  localparam int AW = $clog2(DEPTH);
  localparam logic [AW:0] FULL_CNT = (AW + 1)'(DEPTH);

  stream_beat_t    mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [AW:0]     count;
  logic            wr_en;
  logic            rd_en;

  assign o_rdy  = (count != FULL_CNT);
  assign o_val  = (count != '0);
  assign o_beat = mem[rd_ptr];
  assign wr_en  = i_val && o_rdy;
  assign rd_en  = o_val && i_rdy;

  always_ff @(posedge i_clk_core) begin
    if (wr_en) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (AW + 1)'(wr_en) - (AW + 1)'(rd_en);
    end
  end

  // Occupancy matches the pointer distance and never passes the depth
  assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    (count <= FULL_CNT) && (count[AW-1:0] == AW'(wr_ptr - rd_ptr)));

endmodule

`default_nettype wire

//--- hdl/cmd_router.sv
// Command router, steers each packet to the system or job queue by message type
`timescale 1ns/1ps
`default_nettype none

module cmd_router (
  input  wire logic                   i_clk_core,
  input  wire logic                   i_rst_core,
  input  wire ctrl_pkg::stream_beat_t i_beat,
  input  wire logic                   i_val,
  output logic                        o_rdy,
  output ctrl_pkg::stream_beat_t      o_beat0,
  output logic                        o_val0,
  input  wire logic                   i_rdy0,
  output ctrl_pkg::stream_beat_t      o_beat1,
  output logic                        o_val1,
  input  wire logic                   i_rdy1
);
  import ctrl_pkg::*;

  hdr_t hdr;
  logic path_sel;
  logic path_l;
  logic pkt_open;
  logic xfer;

  // Start beat decides from its header, later beats follow the latched path
  always_comb begin
    hdr = hdr_t'(i_beat.data);
    if (i_beat.sop) begin
      path_sel = (get_msg_type(hdr.cmd) != 8'd0);
    end else begin
      path_sel = path_l;
    end
  end

  assign o_beat0 = i_beat;
  assign o_beat1 = i_beat;
  assign o_val0  = i_val && !path_sel;
  assign o_val1  = i_val && path_sel;
  assign o_rdy   = path_sel ? i_rdy1 : i_rdy0;
  assign xfer    = i_val && o_rdy;

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      path_l   <= 1'b0;
      pkt_open <= 1'b0;
    end else if (xfer) begin
      if (i_beat.sop) begin
        path_l <= path_sel;
      end
      pkt_open <= !i_beat.eop;
    end
  end

  // Continuation beats only while a packet is open upstream
  assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    (i_val && !i_beat.sop) |-> pkt_open);

endmodule

`default_nettype wire

//--- hdl/ctrl_pkg.sv
// Control package with the stream beat, command header and reply builders
`default_nettype none

package ctrl_pkg;

  // One 64-bit beat of a packet stream
  typedef struct packed {
    logic [63:0] data;
    logic        sop;
    logic        eop;
  } stream_beat_t;

  // Header carried in the first beat of every command and reply
  typedef struct packed {
    logic [15:0] len;
    logic [15:0] cmd;
    logic [31:0] tag;
  } hdr_t;

  // Command codes, upper byte is the message type
  localparam logic [15:0] CMD_FPGA_STATUS = 16'h0000;
  localparam logic [15:0] CMD_RESET_FPGA  = 16'h0001;
  localparam logic [15:0] CMD_RUN_JOB     = 16'h0100;

  // Reply codes have the top bit set
  localparam logic [15:0] RPL_FPGA_STATUS = 16'h8000;
  localparam logic [15:0] RPL_RESET_FPGA  = 16'h8001;
  localparam logic [15:0] RPL_RUN_JOB     = 16'h8100;

  // Reply lengths in beats, header included
  localparam logic [15:0] RPL_LEN_STATUS = 16'd2;
  localparam logic [15:0] RPL_LEN_RESET  = 16'd1;
  localparam logic [15:0] RPL_LEN_JOB    = 16'd2;

  function automatic logic [7:0] get_msg_type(input logic [15:0] cmd);
    return cmd[15:8];
  endfunction

  // First reply beat, a 1-beat reply also ends here
  function automatic stream_beat_t get_rpl_hdr(input logic [15:0] code,
                                               input logic [15:0] len,
                                               input logic [31:0] tag);
    hdr_t         hdr;
    stream_beat_t beat;
    hdr.len   = len;
    hdr.cmd   = code;
    hdr.tag   = tag;
    beat.data = hdr;
    beat.sop  = 1'b1;
    beat.eop  = (len == 16'd1);
    return beat;
  endfunction

  // Closing data word of a 2-beat reply
  function automatic stream_beat_t get_rpl_word(input logic [31:0] hi,
                                                input logic [31:0] lo);
    stream_beat_t beat;
    beat.data = {hi, lo};
    beat.sop  = 1'b0;
    beat.eop  = 1'b1;
    return beat;
  endfunction

endpackage

`default_nettype wire

//--- hdl/ctrl_top.sv
// Command control top, routes host commands to two queues and merges the replies
`timescale 1ns/1ps
`default_nettype none

module ctrl_top #(
  parameter logic [31:0] BUILD_ID     = 32'h0000_0001,
  parameter int          RESET_CYCLES = 16,
  parameter int          QUEUE_DEPTH  = 16
) (
  input  wire logic                   i_clk_core,
  input  wire logic                   i_rst_core,
  input  wire ctrl_pkg::stream_beat_t i_cmd,
  input  wire logic                   i_cmd_val,
  output logic                        o_cmd_rdy,
  output ctrl_pkg::stream_beat_t      o_rpl,
  output logic                        o_rpl_val,
  input  wire logic                   i_rpl_rdy,
  output ctrl_pkg::stream_beat_t      o_job,
  output logic                        o_job_val,
  input  wire logic                   i_job_rdy,
  input  wire logic [31:0]            i_result,
  input  wire logic                   i_result_val,
  output logic                        o_usr_rst
);
  import ctrl_pkg::*;

  stream_beat_t rt0_beat, rt1_beat, q0_beat, q1_beat, rpl0, rpl1;
  logic         rt0_val, rt0_rdy, rt1_val, rt1_rdy;
  logic         q0_val, q0_rdy, q1_val, q1_rdy;
  logic         rpl0_val, rpl0_rdy, rpl1_val, rpl1_rdy;
  logic         rst_int;

  // User reset clears the datapath but leaves the handlers running
  assign rst_int = i_rst_core || o_usr_rst;

  cmd_router u_cmd_router (
    .i_clk_core (i_clk_core), .i_rst_core (rst_int),
    .i_beat     (i_cmd),      .i_val      (i_cmd_val), .o_rdy  (o_cmd_rdy),
    .o_beat0    (rt0_beat),   .o_val0     (rt0_val),   .i_rdy0 (rt0_rdy),
    .o_beat1    (rt1_beat),   .o_val1     (rt1_val),   .i_rdy1 (rt1_rdy)
  );

  cmd_queue #(.DEPTH (QUEUE_DEPTH)) u_cmd_queue0 (
    .i_clk_core (i_clk_core), .i_rst_core (rst_int),
    .i_beat     (rt0_beat),   .i_val      (rt0_val), .o_rdy (rt0_rdy),
    .o_beat     (q0_beat),    .o_val      (q0_val),  .i_rdy (q0_rdy)
  );

  cmd_queue #(.DEPTH (QUEUE_DEPTH)) u_cmd_queue1 (
    .i_clk_core (i_clk_core), .i_rst_core (rst_int),
    .i_beat     (rt1_beat),   .i_val      (rt1_val), .o_rdy (rt1_rdy),
    .o_beat     (q1_beat),    .o_val      (q1_val),  .i_rdy (q1_rdy)
  );

  sys_cmd_handler #(.BUILD_ID (BUILD_ID), .RESET_CYCLES (RESET_CYCLES)) u_sys_cmd_handler (
    .i_clk_core (i_clk_core), .i_rst_core (i_rst_core),
    .i_beat     (q0_beat),    .i_val      (q0_val),   .o_rdy     (q0_rdy),
    .o_rpl      (rpl0),       .o_rpl_val  (rpl0_val), .i_rpl_rdy (rpl0_rdy),
    .o_usr_rst  (o_usr_rst)
  );

  job_cmd_handler u_job_cmd_handler (
    .i_clk_core   (i_clk_core),   .i_rst_core (i_rst_core),
    .i_beat       (q1_beat),      .i_val      (q1_val),    .o_rdy     (q1_rdy),
    .o_job        (o_job),        .o_job_val  (o_job_val), .i_job_rdy (i_job_rdy),
    .i_result     (i_result),     .i_result_val (i_result_val),
    .o_rpl        (rpl1),         .o_rpl_val  (rpl1_val),  .i_rpl_rdy (rpl1_rdy)
  );

  reply_arb u_reply_arb (
    .i_clk_core (i_clk_core), .i_rst_core (rst_int),
    .i_rpl0     (rpl0),       .i_val0     (rpl0_val),  .o_rdy0    (rpl0_rdy),
    .i_rpl1     (rpl1),       .i_val1     (rpl1_val),  .o_rdy1    (rpl1_rdy),
    .o_rpl      (o_rpl),      .o_rpl_val  (o_rpl_val), .i_rpl_rdy (i_rpl_rdy)
  );

endmodule

`default_nettype wire

//--- hdl/job_cmd_handler.sv
// Job command handler, streams the job payload to the engine and replies with its result
`timescale 1ns/1ps
`default_nettype none

module job_cmd_handler (
  input  wire logic                   i_clk_core,
  input  wire logic                   i_rst_core,
  input  wire ctrl_pkg::stream_beat_t i_beat,
  input  wire logic                   i_val,
  output logic                        o_rdy,
  output ctrl_pkg::stream_beat_t      o_job,
  output logic                        o_job_val,
  input  wire logic                   i_job_rdy,
  input  wire logic [31:0]            i_result,
  input  wire logic                   i_result_val,
  output ctrl_pkg::stream_beat_t      o_rpl,
  output logic                        o_rpl_val,
  input  wire logic                   i_rpl_rdy
);
  import ctrl_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE, ST_INDEX, ST_FWD, ST_WAIT, ST_REPLY, ST_IGNORE
  } state_t;

  state_t      state;
  hdr_t        hdr;
  logic [31:0] tag_l;
  logic [31:0] job_idx;
  logic [31:0] res_l;
  logic        res_seen;
  logic        first_l;
  logic        in_xfer;
  logic        rpl_xfer;
  logic        job_active;

  assign hdr        = hdr_t'(i_beat.data);
  assign in_xfer    = i_val && o_rdy;
  assign rpl_xfer   = o_rpl_val && i_rpl_rdy;
  assign job_active = (state == ST_INDEX) || (state == ST_FWD) || (state == ST_WAIT);

  // Payload passes straight through to the engine, ready comes back from it
  always_comb begin
    o_job     = i_beat;
    o_job.sop = first_l;
    o_job_val = i_val && (state == ST_FWD);
    case (state)
      ST_FWD:            o_rdy = i_job_rdy;
      ST_WAIT, ST_REPLY: o_rdy = 1'b0;
      default:           o_rdy = 1'b1;
    endcase
  end

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      state     <= ST_IDLE;
      o_rpl_val <= 1'b0;
      res_seen  <= 1'b0;
      first_l   <= 1'b0;
    end else begin
      // Only the first result pulse of a job counts
      if (i_result_val && !res_seen && job_active) begin
        res_l    <= i_result;
        res_seen <= 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (in_xfer) begin
            tag_l <= hdr.tag;
            if (hdr.cmd == CMD_RUN_JOB && !i_beat.eop) begin
              state <= ST_INDEX;
            end else if (!i_beat.eop) begin
              state <= ST_IGNORE;
            end
          end
        end
        ST_INDEX: begin
          if (in_xfer) begin
            job_idx <= i_beat.data[31:0];
            first_l <= 1'b1;
            state   <= i_beat.eop ? ST_WAIT : ST_FWD;
          end
        end
        ST_FWD: begin
          if (in_xfer) begin
            first_l <= 1'b0;
            if (i_beat.eop) begin
              state <= ST_WAIT;
            end
          end
        end
        ST_WAIT: begin
          if (res_seen || i_result_val) begin
            o_rpl     <= get_rpl_hdr(RPL_RUN_JOB, RPL_LEN_JOB, tag_l);
            o_rpl_val <= 1'b1;
            state     <= ST_REPLY;
          end
        end
        ST_REPLY: begin
          if (rpl_xfer) begin
            if (o_rpl.eop) begin
              o_rpl_val <= 1'b0;
              res_seen  <= 1'b0;
              state     <= ST_IDLE;
            end else begin
              o_rpl <= get_rpl_word(job_idx, res_l);
            end
          end
        end
        ST_IGNORE: begin
          if (in_xfer && i_beat.eop) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Engine beat holds while stalled, the queue behind must hold it too
  assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    (o_job_val && !i_job_rdy) |=> (o_job_val && $stable(o_job)));

endmodule

`default_nettype wire

//--- hdl/reply_arb.sv
// Reply arbiter that merges two reply streams round-robin without interleaving packets
`timescale 1ns/1ps
`default_nettype none

module reply_arb (
  input  wire logic                   i_clk_core,
  input  wire logic                   i_rst_core,
  input  wire ctrl_pkg::stream_beat_t i_rpl0,
  input  wire logic                   i_val0,
  output logic                        o_rdy0,
  input  wire ctrl_pkg::stream_beat_t i_rpl1,
  input  wire logic                   i_val1,
  output logic                        o_rdy1,
  output ctrl_pkg::stream_beat_t      o_rpl,
  output logic                        o_rpl_val,
  input  wire logic                   i_rpl_rdy
);
  import ctrl_pkg::*;

  stream_beat_t sel_beat;
  logic         sel;
  logic         sel_val;
  logic         grant;
  logic         locked;
  logic         out_free;
  logic         accept;

  // The grant stays inside a packet and flips at a boundary when both sides wait
  always_comb begin
    if (locked) begin
      sel = grant;
    end else if (i_val0 && i_val1) begin
      sel = !grant;
    end else begin
      sel = i_val1;
    end
    sel_beat = sel ? i_rpl1 : i_rpl0;
    sel_val  = sel ? i_val1 : i_val0;
  end

  assign out_free = !o_rpl_val || i_rpl_rdy;
  assign accept   = sel_val && out_free;
  assign o_rdy0   = out_free && !sel;
  assign o_rdy1   = out_free && sel;

  always_ff @(posedge i_clk_core) begin
    if (accept) begin
      o_rpl <= sel_beat;
    end
  end

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      o_rpl_val <= 1'b0;
      grant     <= 1'b0;
      locked    <= 1'b0;
    end else if (accept) begin
      o_rpl_val <= 1'b1;
      grant     <= sel;
      locked    <= !sel_beat.eop;
    end else if (i_rpl_rdy) begin
      o_rpl_val <= 1'b0;
    end
  end

  // Start beats are taken only while no packet is open
  assert property (@(posedge i_clk_core) disable iff (i_rst_core)
    accept |-> (sel_beat.sop == !locked));

endmodule

`default_nettype wire

//--- hdl/sys_cmd_handler.sv
// System command handler, serves status and reset commands and builds their replies
`timescale 1ns/1ps
`default_nettype none

module sys_cmd_handler #(
  parameter logic [31:0] BUILD_ID     = 32'h0000_0001,
  parameter int          RESET_CYCLES = 16
) (
  input  wire logic                   i_clk_core,
  input  wire logic                   i_rst_core,
  input  wire ctrl_pkg::stream_beat_t i_beat,
  input  wire logic                   i_val,
  output logic                        o_rdy,
  output ctrl_pkg::stream_beat_t      o_rpl,
  output logic                        o_rpl_val,
  input  wire logic                   i_rpl_rdy,
  output logic                        o_usr_rst
);
  import ctrl_pkg::*;

  localparam int CW = $clog2(RESET_CYCLES + 1);

  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_SEND   = 2'd1,
    ST_RESET  = 2'd2,
    ST_IGNORE = 2'd3
  } state_t;

  state_t        state;
  hdr_t          hdr;
  logic [31:0]   tag_l;
  logic          drain_l;
  logic [CW-1:0] rst_cnt;
  logic          in_xfer;
  logic          rpl_xfer;

  assign hdr      = hdr_t'(i_beat.data);
  assign o_rdy    = (state == ST_IDLE) || (state == ST_IGNORE);
  assign in_xfer  = i_val && o_rdy;
  assign rpl_xfer = o_rpl_val && i_rpl_rdy;

  always_ff @(posedge i_clk_core) begin
    if (i_rst_core) begin
      state     <= ST_IDLE;
      o_rpl_val <= 1'b0;
      o_usr_rst <= 1'b0;
      drain_l   <= 1'b0;
      rst_cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (in_xfer) begin
            tag_l   <= hdr.tag;
            drain_l <= !i_beat.eop;
            case (hdr.cmd)
              CMD_FPGA_STATUS: begin
                o_rpl     <= get_rpl_hdr(RPL_FPGA_STATUS, RPL_LEN_STATUS, hdr.tag);
                o_rpl_val <= 1'b1;
                state     <= ST_SEND;
              end
              CMD_RESET_FPGA: begin
                o_usr_rst <= 1'b1;
                rst_cnt   <= CW'(RESET_CYCLES - 1);
                state     <= ST_RESET;
              end
              default: begin
                if (!i_beat.eop) begin
                  state <= ST_IGNORE;
                end
              end
            endcase
          end
        end
        // Shared by the status and reset replies
        ST_SEND: begin
          if (rpl_xfer) begin
            if (o_rpl.eop) begin
              o_rpl_val <= 1'b0;
              state     <= drain_l ? ST_IGNORE : ST_IDLE;
            end else begin
              o_rpl <= get_rpl_word(BUILD_ID, 32'(state));
            end
          end
        end
        ST_RESET: begin
          if (o_usr_rst) begin
            if (rst_cnt == '0) begin
              o_usr_rst <= 1'b0;
            end else begin
              rst_cnt <= rst_cnt - 1'b1;
            end
          end else begin
            // User reset flushed the rest of the queue
            drain_l   <= 1'b0;
            o_rpl     <= get_rpl_hdr(RPL_RESET_FPGA, RPL_LEN_RESET, tag_l);
            o_rpl_val <= 1'b1;
            state     <= ST_SEND;
          end
        end
        ST_IGNORE: begin
          if (in_xfer && i_beat.eop) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log for failures

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_ctrl_top -f sources.f -o tb_ctrl_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_ctrl_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$LOG"; then
  exit 1
fi
exit 0

//--- sources.f
hdl/ctrl_pkg.sv
hdl/cmd_router.sv
hdl/cmd_queue.sv
hdl/sys_cmd_handler.sv
hdl/job_cmd_handler.sv
hdl/reply_arb.sv
hdl/ctrl_top.sv
tests/tb_ctrl_top.sv

//--- tests/tb_ctrl_top.sv
// Testbench that runs directed command tests on the command control top against an engine model
`timescale 1ns/1ps
`default_nettype none

module tb_ctrl_top;
  import ctrl_pkg::*;

  localparam logic [31:0] BUILD_ID     = 32'h5A17_0003;
  localparam int          RESET_CYCLES = 16;
  localparam int          QUEUE_DEPTH  = 16;
  localparam int          TMO          = 2000;
  // Status word reports the handler state, and send status comes second after idle
  localparam logic [31:0] SEND_STATE   = 32'd1;

  logic         i_clk_core;
  logic         i_rst_core;
  stream_beat_t i_cmd;
  logic         i_cmd_val;
  logic         o_cmd_rdy;
  stream_beat_t o_rpl;
  logic         o_rpl_val;
  logic         i_rpl_rdy;
  stream_beat_t o_job;
  logic         o_job_val;
  logic         i_job_rdy;
  logic [31:0]  i_result;
  logic         i_result_val;
  logic         o_usr_rst;

  stream_beat_t tx_q[$];
  stream_beat_t rx_q[$];
  stream_beat_t rx_pkt[$];
  stream_beat_t job_q[$];
  logic [63:0]  pay_q[$];
  logic [31:0]  res_q[$];
  int           errors = 0;
  int           tests = 0;
  logic         rdy_random = 1'b0;
  integer       seed = 32'ha9c9;
  integer       rdy_seed = 32'ha9c9;

  ctrl_top #(
    .BUILD_ID     (BUILD_ID),
    .RESET_CYCLES (RESET_CYCLES),
    .QUEUE_DEPTH  (QUEUE_DEPTH)
  ) u_ctrl_top (
    .i_clk_core   (i_clk_core),
    .i_rst_core   (i_rst_core),
    .i_cmd        (i_cmd),
    .i_cmd_val    (i_cmd_val),
    .o_cmd_rdy    (o_cmd_rdy),
    .o_rpl        (o_rpl),
    .o_rpl_val    (o_rpl_val),
    .i_rpl_rdy    (i_rpl_rdy),
    .o_job        (o_job),
    .o_job_val    (o_job_val),
    .i_job_rdy    (i_job_rdy),
    .i_result     (i_result),
    .i_result_val (i_result_val),
    .o_usr_rst    (o_usr_rst)
  );

  initial begin
    i_clk_core = 1'b0;
    forever #4 i_clk_core = ~i_clk_core;
  end

  // Engine model that takes every payload beat and answers each finished job from res_q
  initial begin : engine_model
    int pending;
    pending = 0;
    i_result     <= '0;
    i_result_val <= 1'b0;
    forever begin
      @(posedge i_clk_core);
      if (o_job_val && i_job_rdy) begin
        job_q.push_back(o_job);
        if (o_job.eop) begin
          pending++;
        end
      end
      if (pending > 0 && res_q.size() > 0) begin
        i_result     <= res_q.pop_front();
        i_result_val <= 1'b1;
        pending--;
      end else begin
        i_result_val <= 1'b0;
      end
    end
  end

  // Reply sink that collects accepted beats and toggles both readies when asked
  initial begin : reply_sink
    logic [31:0] r;
    i_rpl_rdy <= 1'b1;
    i_job_rdy <= 1'b1;
    forever begin
      @(posedge i_clk_core);
      if (o_rpl_val && i_rpl_rdy) begin
        rx_q.push_back(o_rpl);
      end
      r = $random(rdy_seed);
      i_rpl_rdy <= rdy_random ? r[0] : 1'b1;
      i_job_rdy <= rdy_random ? r[1] : 1'b1;
    end
  end

  // Header beat laid out as length, command code and tag from the top bits down
  function automatic stream_beat_t hdr_beat(input logic [15:0] cmd, input logic [15:0] len,
                                            input logic [31:0] tag);
    stream_beat_t b;
    b.data = {len, cmd, tag};
    b.sop  = 1'b1;
    b.eop  = (len == 16'd1);
    return b;
  endfunction

  function automatic stream_beat_t data_beat(input logic [63:0] data, input logic last);
    stream_beat_t b;
    b.data = data;
    b.sop  = 1'b0;
    b.eop  = last;
    return b;
  endfunction

  function automatic bit eop_waiting();
    int i;
    for (i = 0; i < rx_q.size(); i++) begin
      if (rx_q[i].eop) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int e0);
    tests++;
    if (errors == e0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - e0);
    end
  endtask

  // Command with a number of filler beats after the header
  task automatic queue_cmd(input logic [15:0] cmd, input logic [31:0] tag, input int extra);
    logic [63:0] w;
    int          i;
    tx_q.push_back(hdr_beat(cmd, 16'(extra + 1), tag));
    for (i = 1; i <= extra; i++) begin
      w = {$random(seed), $random(seed)};
      tx_q.push_back(data_beat(w, i == extra));
    end
  endtask

  // Job packet is header, index word, then three payload words
  task automatic queue_job(input logic [31:0] tag, input logic [31:0] idx);
    logic [63:0] w;
    int          i;
    pay_q.delete();
    tx_q.push_back(hdr_beat(CMD_RUN_JOB, 16'd5, tag));
    tx_q.push_back(data_beat({32'h0, idx}, 1'b0));
    for (i = 0; i < 3; i++) begin
      w = {$random(seed), $random(seed)};
      pay_q.push_back(w);
      tx_q.push_back(data_beat(w, i == 2));
    end
  endtask

  task automatic send_tx();
    stream_beat_t b;
    int           n;
    while (tx_q.size() > 0) begin
      b = tx_q.pop_front();
      i_cmd     <= b;
      i_cmd_val <= 1'b1;
      n = 0;
      do begin
        @(posedge i_clk_core);
        n++;
      end while (!o_cmd_rdy && n < TMO);
      if (!o_cmd_rdy) begin
        $display("Timed out waiting for the command stream to take a beat");
        errors++;
      end
    end
    i_cmd_val <= 1'b0;
  endtask

  task automatic recv_packet();
    stream_beat_t b;
    int           n;
    int           i;
    rx_pkt.delete();
    n = 0;
    while (!eop_waiting() && n < TMO) begin
      @(posedge i_clk_core);
      n++;
    end
    if (!eop_waiting()) begin
      $display("Timed out waiting for a reply packet");
      errors++;
    end else begin
      do begin
        b = rx_q.pop_front();
        rx_pkt.push_back(b);
      end while (!b.eop);
      assert (rx_pkt[0].sop) else begin
        $display("Reply packet does not begin with a start flag");
        errors++;
      end
      for (i = 1; i < rx_pkt.size(); i++) begin
        assert (!rx_pkt[i].sop) else begin
          $display("Start flag found inside a reply packet");
          errors++;
        end
      end
    end
  endtask

  task automatic check_reply(input logic [15:0] code, input logic [15:0] len,
                             input logic [31:0] tag, input logic [31:0] hi,
                             input logic [31:0] lo);
    hdr_t h;
    expect_eq("reply beats", 64'(rx_pkt.size()), 64'(len));
    if (rx_pkt.size() == int'(len)) begin
      h = hdr_t'(rx_pkt[0].data);
      expect_eq("o_rpl.len", 64'(h.len), 64'(len));
      expect_eq("o_rpl.cmd", 64'(h.cmd), 64'(code));
      expect_eq("o_rpl.tag", 64'(h.tag), 64'(tag));
      if (len == 16'd2) begin
        expect_eq("o_rpl.data[63:32]", 64'(rx_pkt[1].data[63:32]), 64'(hi));
        expect_eq("o_rpl.data[31:0]", 64'(rx_pkt[1].data[31:0]), 64'(lo));
      end
    end
  endtask

  task automatic status_roundtrip();
    logic [31:0] tag;
    tag = $random(seed);
    queue_cmd(CMD_FPGA_STATUS, tag, 0);
    send_tx();
    recv_packet();
    check_reply(RPL_FPGA_STATUS, 16'd2, tag, BUILD_ID, SEND_STATE);
  endtask

  task automatic status_cmd();
    int e0;
    e0 = errors;
    status_roundtrip();
    end_test("status", e0);
  endtask

  task automatic job_cmd();
    int          e0;
    int          i;
    logic [31:0] tag;
    logic [31:0] idx;
    logic [31:0] res;
    e0 = errors;
    job_q.delete();
    tag = $random(seed);
    idx = $random(seed);
    res = $random(seed);
    res_q.push_back(res);
    queue_job(tag, idx);
    send_tx();
    recv_packet();
    check_reply(RPL_RUN_JOB, 16'd2, tag, idx, res);
    expect_eq("o_job beats", 64'(job_q.size()), 64'd3);
    if (job_q.size() == 3) begin
      for (i = 0; i < 3; i++) begin
        expect_eq("o_job.data", job_q[i].data, pay_q[i]);
        expect_eq("o_job.sop", 64'(job_q[i].sop), 64'(i == 0));
        expect_eq("o_job.eop", 64'(job_q[i].eop), 64'(i == 2));
      end
    end
    end_test("job", e0);
  endtask

  task automatic status_during_job();
    int          e0;
    int          n;
    logic [31:0] tag;
    logic [31:0] idx;
    logic [31:0] res;
    e0 = errors;
    job_q.delete();
    tag = $random(seed);
    idx = $random(seed);
    res = $random(seed);
    queue_job(tag, idx);
    send_tx();
    n = 0;
    while (job_q.size() < 3 && n < TMO) begin
      @(posedge i_clk_core);
      n++;
    end
    if (job_q.size() < 3) begin
      $display("Timed out waiting for the job payload at the engine");
      errors++;
    end
    // Job now waits on its result while status still comes back first
    status_roundtrip();
    res_q.push_back(res);
    recv_packet();
    check_reply(RPL_RUN_JOB, 16'd2, tag, idx, res);
    end_test("status_during_job", e0);
  endtask

  task automatic reset_cmd();
    int          e0;
    int          n;
    int          hi;
    logic [31:0] tag;
    e0 = errors;
    tag = $random(seed);
    queue_cmd(CMD_RESET_FPGA, tag, 0);
    send_tx();
    n = 0;
    while (!o_usr_rst && n < TMO) begin
      @(posedge i_clk_core);
      n++;
    end
    if (!o_usr_rst) begin
      $display("User reset never went high");
      errors++;
    end
    hi = 0;
    while (o_usr_rst && hi < TMO) begin
      @(posedge i_clk_core);
      hi++;
    end
    expect_eq("o_usr_rst cycles", 64'(hi), 64'(RESET_CYCLES));
    recv_packet();
    check_reply(RPL_RESET_FPGA, 16'd1, tag, '0, '0);
    status_roundtrip();
    end_test("reset", e0);
  endtask

  task automatic unknown_cmds();
    int e0;
    e0 = errors;
    queue_cmd(16'h0042, $random(seed), 2);
    queue_cmd(16'h01FF, $random(seed), 2);
    send_tx();
    // Unknown codes get no reply so the next one is the status reply
    status_roundtrip();
    expect_eq("replies left", 64'(rx_q.size()), 64'd0);
    end_test("unknown", e0);
  endtask

  task automatic mixed_backpressure();
    int          e0;
    int          k;
    hdr_t        h;
    logic [31:0] tag;
    logic [31:0] idx;
    logic [31:0] res;
    logic [31:0] st_tags[$];
    logic [31:0] jb_tags[$];
    logic [31:0] jb_idx[$];
    logic [31:0] jb_res[$];
    e0 = errors;
    rdy_random = 1'b1;
    for (k = 0; k < 5; k++) begin
      tag = $random(seed);
      if (k % 2 == 0) begin
        st_tags.push_back(tag);
        queue_cmd(CMD_FPGA_STATUS, tag, 0);
      end else begin
        idx = $random(seed);
        res = $random(seed);
        jb_tags.push_back(tag);
        jb_idx.push_back(idx);
        jb_res.push_back(res);
        res_q.push_back(res);
        queue_job(tag, idx);
      end
    end
    send_tx();
    for (k = 0; k < 5; k++) begin
      recv_packet();
      if (rx_pkt.size() > 0) begin
        h = hdr_t'(rx_pkt[0].data);
        if (h.cmd == RPL_RUN_JOB && jb_tags.size() > 0) begin
          check_reply(RPL_RUN_JOB, 16'd2, jb_tags.pop_front(), jb_idx.pop_front(),
                      jb_res.pop_front());
        end else if (st_tags.size() > 0) begin
          check_reply(RPL_FPGA_STATUS, 16'd2, st_tags.pop_front(), BUILD_ID, SEND_STATE);
        end else begin
          $display("Reply packet arrived with no command left to answer");
          errors++;
        end
      end
    end
    rdy_random = 1'b0;
    end_test("backpressure", e0);
  endtask

  initial begin : main
    i_rst_core <= 1'b1;
    i_cmd      <= '0;
    i_cmd_val  <= 1'b0;
    repeat (3) @(posedge i_clk_core);
    i_rst_core <= 1'b0;
    @(posedge i_clk_core);
    status_cmd();
    job_cmd();
    status_during_job();
    reset_cmd();
    unknown_cmds();
    mixed_backpressure();
    $display("Tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
